// ==== hw/bp_pkg.sv ====
package bp_pkg;

    localparam int HISTORY_DEPTH = 8;
    localparam int PHT_ENTRIES = 1 << HISTORY_DEPTH;   // one counter per history pattern

    localparam int BHT_INDEX_BITS = 6;                 // pc[7:2]
    localparam int BHT_ENTRIES = 1 << BHT_INDEX_BITS;

    localparam int CHOOSER_INDEX_BITS = 6;             // pc[7:2]
    localparam int CHOOSER_ENTRIES = 1 << CHOOSER_INDEX_BITS;

    localparam int BTB_INDEX_BITS = 4;                 // pc[5:2]
    localparam int BTB_ENTRIES = 1 << BTB_INDEX_BITS;
    localparam int BTB_TAG_BITS = 32 - BTB_INDEX_BITS - 2;  // pc[31:6]

    typedef logic [31:0] word_t;
    typedef logic [HISTORY_DEPTH-1:0] history_t;
    typedef logic [1:0] ctr2_t;                        // msb set means taken

    localparam ctr2_t CTR_RESET = 2'd1;                // weakly not taken

    typedef enum logic [1:0] {
        kind_br   = 2'b00,
        kind_jal  = 2'b01,
        kind_jalr = 2'b10
    } br_kind_e;

    typedef struct packed {
        logic                    valid;
        logic [BTB_TAG_BITS-1:0] tag;
        word_t                   target;
        br_kind_e                kind;
    } btb_entry_t;

    // saturating step of a 2-bit counter
    function automatic ctr2_t ctr_next(ctr2_t ctr, logic up);
        if (up) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

endpackage

// ==== hw/bp_train_if.sv ====
`timescale 1ns/10ps

interface bp_train_if
import bp_pkg::*;
();

    logic     valid;    // one resolved instruction this cycle
    word_t    pc;
    logic     taken;    // resolved direction, branches only
    br_kind_e kind;
    word_t    target;

    modport source (
        output valid, pc, taken, kind, target
    );

    modport sink (
        input valid, pc, taken, kind, target
    );

endinterface : bp_train_if

// ==== hw/local_predictor.sv ====
`timescale 1ns/10ps

module local_predictor
import bp_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t fetch_pc,
    bp_train_if.sink train,
    output logic  local_taken,
    output logic  local_train_taken
);

    history_t bht [BHT_ENTRIES];    // per-pc branch history
    ctr2_t    pht [PHT_ENTRIES];    // local pattern table

    logic [BHT_INDEX_BITS-1:0] fetch_idx;
    logic [BHT_INDEX_BITS-1:0] train_idx;
    history_t fetch_hist;
    history_t train_hist;
    logic     train_br;

    assign fetch_idx = fetch_pc[BHT_INDEX_BITS+1:2];
    assign train_idx = train.pc[BHT_INDEX_BITS+1:2];

    assign fetch_hist = bht[fetch_idx];
    assign train_hist = bht[train_idx];

    // the history picks the counter, msb is the direction
    assign local_taken = pht[fetch_hist][1];
    assign local_train_taken = pht[train_hist][1];

    assign train_br = train.valid && (train.kind == kind_br);   // jumps leave history alone

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= '0;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CTR_RESET;
            end
        end else if (train_br) begin
            pht[train_hist] <= ctr_next(pht[train_hist], train.taken);
            bht[train_idx] <= {train_hist[HISTORY_DEPTH-2:0], train.taken};  // newest at lsb
        end
    end

endmodule : local_predictor

// ==== hw/global_predictor.sv ====
`timescale 1ns/10ps

module global_predictor
import bp_pkg::*;
(
    input  logic clk,
    input  logic rst,
    bp_train_if.sink train,
    output logic global_taken,
    output logic global_train_taken
);

    history_t ghr;                  // outcomes of the last branches, newest at lsb
    ctr2_t    pht [PHT_ENTRIES];    // global pattern table

    ctr2_t ghr_ctr;
    logic  train_br;

    assign ghr_ctr = pht[ghr];

    // only the shared history selects the counter, so the fetch and
    // training predictions come from the same entry
    assign global_taken = ghr_ctr[1];
    assign global_train_taken = ghr_ctr[1];

    assign train_br = train.valid && (train.kind == kind_br);

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CTR_RESET;
            end
        end else if (train_br) begin
            pht[ghr] <= ctr_next(ghr_ctr, train.taken);   // train before the shift
            ghr <= {ghr[HISTORY_DEPTH-2:0], train.taken};
        end
    end

endmodule : global_predictor

// ==== hw/btb.sv ====
`timescale 1ns/10ps

module btb
import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      fetch_pc,
    bp_train_if.sink   train,
    output logic       hit,
    output btb_entry_t entry
);

    btb_entry_t table_q [BTB_ENTRIES];   // direct mapped

    logic [BTB_INDEX_BITS-1:0] rd_idx;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic [BTB_TAG_BITS-1:0]   rd_tag;
    btb_entry_t rd_entry;
    btb_entry_t wr_entry;

    assign rd_idx = fetch_pc[BTB_INDEX_BITS+1:2];
    assign rd_tag = fetch_pc[31:BTB_INDEX_BITS+2];
    assign wr_idx = train.pc[BTB_INDEX_BITS+1:2];

    assign rd_entry = table_q[rd_idx];
    assign entry = rd_entry;
    assign hit = rd_entry.valid && (rd_entry.tag == rd_tag);

    always_comb begin
        wr_entry.valid = 1'b1;
        wr_entry.tag = train.pc[31:BTB_INDEX_BITS+2];
        wr_entry.kind = train.kind;
        if (train.kind == kind_jalr) begin
            wr_entry.target = {train.target[31:1], 1'b0};   // jalr drops bit 0
        end else begin
            wr_entry.target = train.target;
        end
    end

    // every resolved control-flow instruction claims its slot
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                table_q[i] <= '0;
            end
        end else if (train.valid) begin
            table_q[wr_idx] <= wr_entry;
        end
    end

endmodule : btb

// ==== hw/tournament_chooser.sv ====
`timescale 1ns/10ps

module tournament_chooser
import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      fetch_pc,
    bp_train_if.sink   train,
    input  logic       local_taken,
    input  logic       local_train_taken,
    input  logic       global_taken,
    input  logic       global_train_taken,
    input  logic       hit,
    input  btb_entry_t entry,
    output logic       pred_taken,
    output logic       pred_hit,
    output logic       pred_use_global,
    output br_kind_e   pred_kind,
    output word_t      pred_target,
    output word_t      pred_next_pc
);

    ctr2_t choice [CHOOSER_ENTRIES];    // msb set favors global

    logic [CHOOSER_INDEX_BITS-1:0] fetch_idx;
    logic [CHOOSER_INDEX_BITS-1:0] train_idx;
    logic  chosen_taken;
    word_t seq_pc;
    logic  local_right;
    logic  global_right;
    logic  train_update;

    assign fetch_idx = fetch_pc[CHOOSER_INDEX_BITS+1:2];
    assign train_idx = train.pc[CHOOSER_INDEX_BITS+1:2];

    assign pred_use_global = choice[fetch_idx][1];
    assign chosen_taken = pred_use_global ? global_taken : local_taken;

    // jumps in the btb are always taken
    assign pred_taken = hit && ((entry.kind != kind_br) || chosen_taken);
    assign pred_hit = hit;
    assign pred_kind = entry.kind;
    assign pred_target = entry.target;

    assign seq_pc = fetch_pc + 32'd4;
    assign pred_next_pc = pred_taken ? entry.target : seq_pc;

    assign local_right = (local_train_taken == train.taken);
    assign global_right = (global_train_taken == train.taken);

    // only move when the two predictors disagree on being right
    assign train_update = train.valid && (train.kind == kind_br)
                          && (local_right != global_right);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
                choice[i] <= CTR_RESET;
            end
        end else if (train_update) begin
            choice[train_idx] <= ctr_next(choice[train_idx], global_right);  // up is global
        end
    end

endmodule : tournament_chooser

// ==== hw/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor
import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    fetch_pc,
    input  logic     train_valid,
    input  word_t    train_pc,
    input  logic     train_taken,
    input  br_kind_e train_kind,
    input  word_t    train_target,
    output logic     pred_taken,
    output logic     pred_hit,
    output logic     pred_use_global,
    output br_kind_e pred_kind,
    output word_t    pred_target,
    output word_t    pred_next_pc
);

    bp_train_if train ();

    logic       local_taken;
    logic       local_train_taken;
    logic       global_taken;
    logic       global_train_taken;
    logic       btb_hit;
    btb_entry_t btb_entry;

    // resolved instruction fans out to every table
    assign train.valid = train_valid;
    assign train.pc = train_pc;
    assign train.taken = train_taken;
    assign train.kind = train_kind;
    assign train.target = train_target;

    local_predictor local_predictor (
        .clk(clk),
        .rst(rst),
        .fetch_pc(fetch_pc),
        .train(train.sink),
        .local_taken(local_taken),
        .local_train_taken(local_train_taken)
    );

    global_predictor global_predictor (
        .clk(clk),
        .rst(rst),
        .train(train.sink),
        .global_taken(global_taken),
        .global_train_taken(global_train_taken)
    );

    btb btb (
        .clk(clk),
        .rst(rst),
        .fetch_pc(fetch_pc),
        .train(train.sink),
        .hit(btb_hit),
        .entry(btb_entry)
    );

    tournament_chooser tournament_chooser (
        .clk(clk),
        .rst(rst),
        .fetch_pc(fetch_pc),
        .train(train.sink),
        .local_taken(local_taken),
        .local_train_taken(local_train_taken),
        .global_taken(global_taken),
        .global_train_taken(global_train_taken),
        .hit(btb_hit),
        .entry(btb_entry),
        .pred_taken(pred_taken),
        .pred_hit(pred_hit),
        .pred_use_global(pred_use_global),
        .pred_kind(pred_kind),
        .pred_target(pred_target),
        .pred_next_pc(pred_next_pc)
    );

endmodule : branch_predictor

// ==== test/bp_model.svh ====
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// reference tables indexed straight from pc slices
logic [7:0]  m_bht [64];        // local history per pc[7:2]
logic [1:0]  m_lpht [256];
logic [7:0]  m_ghr;
logic [1:0]  m_gpht [256];
logic [1:0]  m_choice [64];     // 2 and up favors global
logic        m_btb_valid [16];  // slot is pc[5:2]
logic [25:0] m_btb_tag [16];
word_t       m_btb_target [16];
br_kind_e    m_btb_kind [16];

function automatic logic [1:0] sat_step(logic [1:0] c, logic up);
    if (up && c != 2'd3) begin
        return c + 2'd1;
    end
    if (!up && c != 2'd0) begin
        return c - 2'd1;
    end
    return c;
endfunction

task automatic reset_tables();
    m_ghr = 8'd0;
    for (int i = 0; i < 256; i++) begin
        m_lpht[i] = 2'd1;
        m_gpht[i] = 2'd1;
    end
    for (int i = 0; i < 64; i++) begin
        m_bht[i] = 8'd0;
        m_choice[i] = 2'd1;
    end
    for (int i = 0; i < 16; i++) begin
        m_btb_valid[i] = 1'b0;
        m_btb_tag[i] = 26'd0;
        m_btb_target[i] = 32'd0;
        m_btb_kind[i] = kind_br;   // an empty slot reads as all zero
    end
endtask

task automatic predict_outputs(input word_t pc, output logic taken, output logic hit,
                               output logic use_global, output br_kind_e kind,
                               output word_t target, output word_t next_pc);
    logic [5:0] hi;
    logic [3:0] bi;
    logic       dir;
    hi = pc[7:2];
    bi = pc[5:2];
    hit = m_btb_valid[bi] && (m_btb_tag[bi] == pc[31:6]);
    kind = m_btb_kind[bi];
    target = m_btb_target[bi];
    use_global = m_choice[hi][1];
    dir = use_global ? m_gpht[m_ghr][1] : m_lpht[m_bht[hi]][1];
    taken = hit && ((kind != kind_br) || dir);
    next_pc = taken ? target : pc + 32'd4;
endtask

task automatic apply_training(input logic valid, input word_t pc, input logic taken,
                              input br_kind_e kind, input word_t target);
    logic [5:0] hi;
    logic [3:0] bi;
    logic [7:0] hist;
    logic       local_ok;
    logic       global_ok;
    hi = pc[7:2];
    bi = pc[5:2];
    hist = m_bht[hi];
    local_ok = (m_lpht[hist][1] == taken);   // judged before any table moves
    global_ok = (m_gpht[m_ghr][1] == taken);
    if (valid && kind == kind_br) begin
        if (local_ok != global_ok) begin
            m_choice[hi] = sat_step(m_choice[hi], global_ok);
        end
        m_lpht[hist] = sat_step(m_lpht[hist], taken);
        m_bht[hi] = {hist[6:0], taken};
        m_gpht[m_ghr] = sat_step(m_gpht[m_ghr], taken);
        m_ghr = {m_ghr[6:0], taken};
    end
    if (valid) begin
        m_btb_valid[bi] = 1'b1;
        m_btb_tag[bi] = pc[31:6];
        m_btb_kind[bi] = kind;
        m_btb_target[bi] = (kind == kind_jalr) ? (target & 32'hffff_fffe) : target;
    end
endtask

`endif

// ==== test/tb_branch_predictor.sv ====
`timescale 1ns/10ps

module tb_branch_predictor
import bp_pkg::*;
();

    logic     clk;
    logic     rst;
    word_t    fetch_pc;
    logic     train_valid;
    word_t    train_pc;
    logic     train_taken;
    br_kind_e train_kind;
    word_t    train_target;
    logic     pred_taken;
    logic     pred_hit;
    logic     pred_use_global;
    br_kind_e pred_kind;
    word_t    pred_target;
    word_t    pred_next_pc;

    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name = "";
    logic [31:0] lcg_state = 32'd27265;

    `include "bp_model.svh"

    branch_predictor uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_kind(input string what, input br_kind_e expected,
                                input br_kind_e actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %s, actual %s", test_name, what,
                     expected.name(), actual.name());
        end
    endtask

    task automatic check_outputs();
        logic     exp_taken;
        logic     exp_hit;
        logic     exp_global;
        br_kind_e exp_kind;
        word_t    exp_target;
        word_t    exp_next;
        predict_outputs(fetch_pc, exp_taken, exp_hit, exp_global, exp_kind, exp_target, exp_next);
        compare_bit("pred_taken", exp_taken, pred_taken);
        compare_bit("pred_hit", exp_hit, pred_hit);
        compare_bit("pred_use_global", exp_global, pred_use_global);
        compare_kind("pred_kind", exp_kind, pred_kind);
        compare_word("pred_target", exp_target, pred_target);
        compare_word("pred_next_pc", exp_next, pred_next_pc);
    endtask

    // drive on the rising edge and check on the falling one
    task automatic drive_cycle(input word_t fpc, input logic tv, input word_t tpc,
                               input logic tt, input br_kind_e tk, input word_t ttgt);
        @(posedge clk);
        fetch_pc <= fpc;
        train_valid <= tv;
        train_pc <= tpc;
        train_taken <= tt;
        train_kind <= tk;
        train_target <= ttgt;
        @(negedge clk);
        check_outputs();
        apply_training(tv, tpc, tt, tk, ttgt);   // lands on the next edge
    endtask

    task automatic lookup_only(input word_t fpc);
        drive_cycle(fpc, 1'b0, 32'd0, 1'b0, kind_br, 32'd0);
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d mismatches", test_name, (test_errors == 0) ? "ok" : "FAIL",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic after_reset_check();
        word_t pcs [4];
        test_name = "after_reset";
        pcs = '{32'h0000_0000, 32'h0000_1004, 32'h8000_00fc, 32'hffff_fff0};
        foreach (pcs[i]) begin
            lookup_only(pcs[i]);
            compare_bit("pred_hit", 1'b0, pred_hit);
            compare_bit("pred_taken", 1'b0, pred_taken);
            compare_bit("pred_use_global", 1'b0, pred_use_global);
            compare_word("pred_next_pc", pcs[i] + 32'd4, pred_next_pc);
        end
        close_test();
    endtask

    task automatic jump_targets();
        test_name = "jump_targets";
        drive_cycle(32'h0000_1010, 1'b1, 32'h0000_1010, 1'b0, kind_jal, 32'h0000_2000);
        drive_cycle(32'h0000_1020, 1'b1, 32'h0000_1020, 1'b0, kind_jalr, 32'h0000_3001);
        lookup_only(32'h0000_1010);
        compare_bit("pred_hit", 1'b1, pred_hit);
        compare_bit("pred_taken", 1'b1, pred_taken);
        compare_kind("pred_kind", kind_jal, pred_kind);
        compare_word("pred_next_pc", 32'h0000_2000, pred_next_pc);
        lookup_only(32'h0000_1020);
        compare_bit("pred_hit", 1'b1, pred_hit);
        compare_bit("pred_taken", 1'b1, pred_taken);
        compare_kind("pred_kind", kind_jalr, pred_kind);
        compare_word("pred_target", 32'h0000_3000, pred_target);   // bit 0 gone
        lookup_only(32'h0000_1050);   // same slot as 1010 with another tag
        compare_bit("pred_hit", 1'b0, pred_hit);
        compare_word("pred_next_pc", 32'h0000_1054, pred_next_pc);
        drive_cycle(32'h0000_1050, 1'b1, 32'h0000_1050, 1'b0, kind_jal, 32'h0000_4000);
        lookup_only(32'h0000_1050);
        compare_bit("pred_hit", 1'b1, pred_hit);
        compare_word("pred_target", 32'h0000_4000, pred_target);
        lookup_only(32'h0000_1010);   // evicted
        compare_bit("pred_hit", 1'b0, pred_hit);
        close_test();
    endtask

    task automatic branch_warmup();
        int   cycles;
        logic seen;
        test_name = "branch_warmup";
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 40) begin
            drive_cycle(32'h0000_2040, 1'b1, 32'h0000_2040, 1'b1, kind_br, 32'h0000_2100);
            seen = pred_taken;
            cycles++;
        end
        if (!seen) begin
            errors++;
            test_errors++;
            $display("timeout: branch at 00002040 never predicted taken in 40 cycles");
        end
        close_test();
    endtask

    // alternating branch between an always and a never taken one
    task automatic chooser_training();
        logic alt;
        logic went_global;
        test_name = "chooser_training";
        alt = 1'b0;
        went_global = 1'b0;
        for (int i = 0; i < 60; i++) begin
            case (i % 3)
                0: begin
                    drive_cycle(32'h0000_3000, 1'b1, 32'h0000_3000, alt, kind_br, 32'h0000_3400);
                    alt = ~alt;
                end
                1: drive_cycle(32'h0000_3000, 1'b1, 32'h0000_3008, 1'b1, kind_br, 32'h0000_3500);
                default: drive_cycle(32'h0000_3000, 1'b1, 32'h0000_3010, 1'b0, kind_br,
                                     32'h0000_3600);
            endcase
            went_global = went_global | pred_use_global;
        end
        compare_bit("global chosen at 3000", 1'b1, went_global);   // global tracks the pattern
        close_test();
    endtask

    task automatic random_stream();
        word_t       pool [16];
        logic [31:0] r;
        word_t       fpc;
        br_kind_e    kind;
        test_name = "random_stream";
        for (int i = 0; i < 16; i++) begin
            pool[i] = lcg_next() & 32'h0003_0ffc;   // small tag space gives frequent collisions
        end
        for (int n = 0; n < 300; n++) begin
            r = lcg_next();
            case (r[17:16])
                2'd1: kind = kind_jal;
                2'd2: kind = kind_jalr;
                default: kind = kind_br;
            endcase
            fpc = r[20] ? (lcg_next() & 32'h0003_0ffc) : pool[r[27:24]];
            drive_cycle(fpc, r[22:21] != 2'b00, pool[r[31:28]], r[23], kind, lcg_next());
        end
        close_test();
    endtask

    initial begin
        rst <= 1'b1;
        fetch_pc <= 32'd0;
        train_valid <= 1'b0;
        train_pc <= 32'd0;
        train_taken <= 1'b0;
        train_kind <= kind_br;
        train_target <= 32'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        reset_tables();
        after_reset_check();
        jump_targets();
        branch_warmup();
        chooser_training();
        random_stream();
        $display("%0d tests run, %0d failing, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

// ==== verilog.f ====
+incdir+test
hw/bp_pkg.sv
hw/bp_train_if.sv
hw/local_predictor.sv
hw/global_predictor.sv
hw/btb.sv
hw/tournament_chooser.sv
hw/branch_predictor.sv
test/tb_branch_predictor.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_branch_predictor -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# a missing pass line makes grep, and so the script, fail
echo "$out" | grep -q "^Test completed successfully$"
